//--- common/soc_pkg.sv
// Bus widths, load/store address map, and response, target and memory state enums
package soc_pkg;

    // Bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = DATA_W / 8;

    // Byte offset bits within one 64-bit word
    localparam int WORD_LSB = 3;

    // Local data memory region
    localparam logic [ADDR_W-1:0] LMEM_BASE = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] LMEM_SIZE = 32'h0000_2000;

    // Closely coupled data memory region
    localparam logic [ADDR_W-1:0] DCCM_BASE = 32'hF004_0000;
    localparam logic [ADDR_W-1:0] DCCM_SIZE = 32'h0000_1000;

    // Response status, encoded as AXI rresp
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    // Where a load/store request was routed
    typedef enum logic [1:0] {
        TGT_LMEM = 2'd0,
        TGT_DCCM = 2'd1,
        TGT_NONE = 2'd2
    } target_e;

    // Memory response register state
    typedef enum logic {
        MS_IDLE = 1'b0,
        MS_RESP = 1'b1
    } mem_state_e;

endpackage

//--- mem/mem_slave.sv
// Single-port word memory with byte strobes and a registered response
module mem_slave
    import soc_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  logic              core_clk,
    input  logic              rst_i,

    // Request channel
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  logic              req_write_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0] req_strb_i,

    // Response channel
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic [DATA_W-1:0] rsp_rdata_o,
    output resp_e             rsp_resp_o
);

    localparam int IDX_W  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int WADR_W = ADDR_W - WORD_LSB;

    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    mem_state_e        state_q;
    logic [DATA_W-1:0] rsp_rdata_q;

    logic [WADR_W-1:0] word_addr;
    logic [IDX_W-1:0]  word_idx;
    logic              req_accept;

    // Byte offset dropped, upper bits fold back into the array
    assign word_addr = req_addr_i[ADDR_W-1:WORD_LSB];
    assign word_idx  = IDX_W'(word_addr % MEM_WORDS);

    // Free slot, or the held response leaves this cycle
    assign req_ready_o = (state_q == MS_IDLE) || rsp_ready_i;
    assign req_accept  = req_valid_i && req_ready_o;

    assign rsp_valid_o = (state_q == MS_RESP);
    assign rsp_rdata_o = rsp_rdata_q;
    assign rsp_resp_o  = RESP_OKAY;

    // Response state
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            state_q <= MS_IDLE;
        end else if (req_accept) begin
            state_q <= MS_RESP;
        end else if (rsp_ready_i) begin
            state_q <= MS_IDLE;
        end
    end

    // Array update and response data
    always_ff @(posedge core_clk) begin
        if (req_accept) begin
            if (req_write_i) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (req_strb_i[b]) begin
                        mem_q[word_idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                    end
                end
                // Writes answer with zero data
                rsp_rdata_q <= '0;
            end else begin
                rsp_rdata_q <= mem_q[word_idx];
            end
        end
    end

endmodule

//--- bridge/resp_order_fifo.sv
// Circular FIFO of load/store request targets awaiting a response
module resp_order_fifo
    import soc_pkg::*;
#(
    parameter int ORDER_DEPTH = 4
) (
    input  logic    core_clk,
    input  logic    rst_i,
    input  logic    push_i,
    input  target_e push_tgt_i,
    input  logic    pop_i,
    output logic    full_o,
    output logic    empty_o,
    output target_e head_tgt_o
);

    localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    target_e          tgt_q [ORDER_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    assign full_o     = (count_q == CNT_W'(ORDER_DEPTH));
    assign empty_o    = (count_q == '0);
    assign head_tgt_o = tgt_q[rd_ptr_q];

    // Pointers and occupancy
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge core_clk) begin
        if (push_i) begin
            tgt_q[wr_ptr_q] <= push_tgt_i;
        end
    end

endmodule

//--- bridge/lsu_bridge.sv
// Load/store address decode, request routing, decode-error responder and in-order return
module lsu_bridge
    import soc_pkg::*;
#(
    parameter int ORDER_DEPTH = 4
) (
    input  logic              core_clk,
    input  logic              rst_i,

    // Load/store master
    input  logic              m_req_valid_i,
    output logic              m_req_ready_o,
    input  logic              m_req_write_i,
    input  logic [ADDR_W-1:0] m_req_addr_i,
    input  logic [DATA_W-1:0] m_req_wdata_i,
    input  logic [STRB_W-1:0] m_req_strb_i,
    output logic              m_rsp_valid_o,
    input  logic              m_rsp_ready_i,
    output logic [DATA_W-1:0] m_rsp_rdata_o,
    output resp_e             m_rsp_resp_o,

    // Slave 0, local data memory
    output logic              s0_req_valid_o,
    input  logic              s0_req_ready_i,
    output logic              s0_req_write_o,
    output logic [ADDR_W-1:0] s0_req_addr_o,
    output logic [DATA_W-1:0] s0_req_wdata_o,
    output logic [STRB_W-1:0] s0_req_strb_o,
    input  logic              s0_rsp_valid_i,
    output logic              s0_rsp_ready_o,
    input  logic [DATA_W-1:0] s0_rsp_rdata_i,
    input  resp_e             s0_rsp_resp_i,

    // Slave 1, DCCM
    output logic              s1_req_valid_o,
    input  logic              s1_req_ready_i,
    output logic              s1_req_write_o,
    output logic [ADDR_W-1:0] s1_req_addr_o,
    output logic [DATA_W-1:0] s1_req_wdata_o,
    output logic [STRB_W-1:0] s1_req_strb_o,
    input  logic              s1_rsp_valid_i,
    output logic              s1_rsp_ready_o,
    input  logic [DATA_W-1:0] s1_rsp_rdata_i,
    input  resp_e             s1_rsp_resp_i
);

    logic [ADDR_W-1:0] lmem_off;
    logic [ADDR_W-1:0] dccm_off;
    target_e           req_tgt;
    logic              tgt_ready;
    logic              push;
    logic              pop;
    logic              fifo_full;
    logic              fifo_empty;
    target_e           head_tgt;
    logic              sel_valid;
    logic              derr_valid_q;
    logic              derr_take;

    // Region offsets double as the rebased slave addresses
    assign lmem_off = m_req_addr_i - LMEM_BASE;
    assign dccm_off = m_req_addr_i - DCCM_BASE;

    always_comb begin
        if (lmem_off < LMEM_SIZE) begin
            req_tgt = TGT_LMEM;
        end else if (dccm_off < DCCM_SIZE) begin
            req_tgt = TGT_DCCM;
        end else begin
            req_tgt = TGT_NONE;
        end
    end

    // Error slot frees up when its response leaves this cycle
    always_comb begin
        case (req_tgt)
            TGT_LMEM: tgt_ready = s0_req_ready_i;
            TGT_DCCM: tgt_ready = s1_req_ready_i;
            default:  tgt_ready = !derr_valid_q || derr_take;
        endcase
    end

    assign m_req_ready_o = !fifo_full && tgt_ready;
    assign push          = m_req_valid_i && m_req_ready_o;

    // Request fan-out, only valid is steered
    assign s0_req_valid_o = m_req_valid_i && !fifo_full && (req_tgt == TGT_LMEM);
    assign s0_req_write_o = m_req_write_i;
    assign s0_req_addr_o  = lmem_off;
    assign s0_req_wdata_o = m_req_wdata_i;
    assign s0_req_strb_o  = m_req_strb_i;

    assign s1_req_valid_o = m_req_valid_i && !fifo_full && (req_tgt == TGT_DCCM);
    assign s1_req_write_o = m_req_write_i;
    assign s1_req_addr_o  = dccm_off;
    assign s1_req_wdata_o = m_req_wdata_i;
    assign s1_req_strb_o  = m_req_strb_i;

    resp_order_fifo #(
        .ORDER_DEPTH (ORDER_DEPTH)
    ) order_fifo (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .push_i     (push),
        .push_tgt_i (req_tgt),
        .pop_i      (pop),
        .full_o     (fifo_full),
        .empty_o    (fifo_empty),
        .head_tgt_o (head_tgt)
    );

    // Response from the oldest outstanding target only
    always_comb begin
        case (head_tgt)
            TGT_LMEM: begin
                sel_valid     = s0_rsp_valid_i;
                m_rsp_rdata_o = s0_rsp_rdata_i;
                m_rsp_resp_o  = s0_rsp_resp_i;
            end
            TGT_DCCM: begin
                sel_valid     = s1_rsp_valid_i;
                m_rsp_rdata_o = s1_rsp_rdata_i;
                m_rsp_resp_o  = s1_rsp_resp_i;
            end
            default: begin
                sel_valid     = derr_valid_q;
                m_rsp_rdata_o = '0;
                m_rsp_resp_o  = RESP_DECERR;
            end
        endcase
    end

    assign m_rsp_valid_o  = !fifo_empty && sel_valid;
    assign pop            = m_rsp_valid_o && m_rsp_ready_i;
    assign s0_rsp_ready_o = m_rsp_ready_i && !fifo_empty && (head_tgt == TGT_LMEM);
    assign s1_rsp_ready_o = m_rsp_ready_i && !fifo_empty && (head_tgt == TGT_DCCM);
    assign derr_take      = pop && (head_tgt == TGT_NONE);

    // One-entry decode-error responder
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            derr_valid_q <= 1'b0;
        end else if (push && (req_tgt == TGT_NONE)) begin
            derr_valid_q <= 1'b1;
        end else if (derr_take) begin
            derr_valid_q <= 1'b0;
        end
    end

endmodule

//--- verilog/rev_top.sv
// Memory subsystem top with fetch memory, load/store bridge, LMEM and DCCM
module rev_top
    import soc_pkg::*;
#(
    parameter int IMEM_WORDS  = 256,
    parameter int LMEM_WORDS  = 1024,
    parameter int DCCM_WORDS  = 512,
    parameter int ORDER_DEPTH = 4
) (
    input  logic              core_clk,
    input  logic              rst_i,

    // Instruction fetch port, writes load the program
    input  logic              ifu_req_valid_i,
    output logic              ifu_req_ready_o,
    input  logic              ifu_req_write_i,
    input  logic [ADDR_W-1:0] ifu_req_addr_i,
    input  logic [DATA_W-1:0] ifu_req_wdata_i,
    input  logic [STRB_W-1:0] ifu_req_strb_i,
    output logic              ifu_rsp_valid_o,
    input  logic              ifu_rsp_ready_i,
    output logic [DATA_W-1:0] ifu_rsp_rdata_o,
    output resp_e             ifu_rsp_resp_o,

    // Load/store port
    input  logic              lsu_req_valid_i,
    output logic              lsu_req_ready_o,
    input  logic              lsu_req_write_i,
    input  logic [ADDR_W-1:0] lsu_req_addr_i,
    input  logic [DATA_W-1:0] lsu_req_wdata_i,
    input  logic [STRB_W-1:0] lsu_req_strb_i,
    output logic              lsu_rsp_valid_o,
    input  logic              lsu_rsp_ready_i,
    output logic [DATA_W-1:0] lsu_rsp_rdata_o,
    output resp_e             lsu_rsp_resp_o
);

    // Bridge to LMEM
    logic              lmem_req_valid;
    logic              lmem_req_ready;
    logic              lmem_req_write;
    logic [ADDR_W-1:0] lmem_req_addr;
    logic [DATA_W-1:0] lmem_req_wdata;
    logic [STRB_W-1:0] lmem_req_strb;
    logic              lmem_rsp_valid;
    logic              lmem_rsp_ready;
    logic [DATA_W-1:0] lmem_rsp_rdata;
    resp_e             lmem_rsp_resp;

    // Bridge to DCCM
    logic              dccm_req_valid;
    logic              dccm_req_ready;
    logic              dccm_req_write;
    logic [ADDR_W-1:0] dccm_req_addr;
    logic [DATA_W-1:0] dccm_req_wdata;
    logic [STRB_W-1:0] dccm_req_strb;
    logic              dccm_rsp_valid;
    logic              dccm_rsp_ready;
    logic [DATA_W-1:0] dccm_rsp_rdata;
    resp_e             dccm_rsp_resp;

    mem_slave #(.MEM_WORDS(IMEM_WORDS)) imem (
        .core_clk (core_clk), .rst_i (rst_i),
        .req_valid_i (ifu_req_valid_i), .req_ready_o (ifu_req_ready_o),
        .req_write_i (ifu_req_write_i), .req_addr_i  (ifu_req_addr_i),
        .req_wdata_i (ifu_req_wdata_i), .req_strb_i  (ifu_req_strb_i),
        .rsp_valid_o (ifu_rsp_valid_o), .rsp_ready_i (ifu_rsp_ready_i),
        .rsp_rdata_o (ifu_rsp_rdata_o), .rsp_resp_o  (ifu_rsp_resp_o)
    );

    mem_slave #(.MEM_WORDS(LMEM_WORDS)) lmem (
        .core_clk (core_clk), .rst_i (rst_i),
        .req_valid_i (lmem_req_valid), .req_ready_o (lmem_req_ready),
        .req_write_i (lmem_req_write), .req_addr_i  (lmem_req_addr),
        .req_wdata_i (lmem_req_wdata), .req_strb_i  (lmem_req_strb),
        .rsp_valid_o (lmem_rsp_valid), .rsp_ready_i (lmem_rsp_ready),
        .rsp_rdata_o (lmem_rsp_rdata), .rsp_resp_o  (lmem_rsp_resp)
    );

    mem_slave #(.MEM_WORDS(DCCM_WORDS)) dccm (
        .core_clk (core_clk), .rst_i (rst_i),
        .req_valid_i (dccm_req_valid), .req_ready_o (dccm_req_ready),
        .req_write_i (dccm_req_write), .req_addr_i  (dccm_req_addr),
        .req_wdata_i (dccm_req_wdata), .req_strb_i  (dccm_req_strb),
        .rsp_valid_o (dccm_rsp_valid), .rsp_ready_i (dccm_rsp_ready),
        .rsp_rdata_o (dccm_rsp_rdata), .rsp_resp_o  (dccm_rsp_resp)
    );

    lsu_bridge #(.ORDER_DEPTH(ORDER_DEPTH)) bridge (
        .core_clk (core_clk), .rst_i (rst_i),
        .m_req_valid_i  (lsu_req_valid_i), .m_req_ready_o  (lsu_req_ready_o),
        .m_req_write_i  (lsu_req_write_i), .m_req_addr_i   (lsu_req_addr_i),
        .m_req_wdata_i  (lsu_req_wdata_i), .m_req_strb_i   (lsu_req_strb_i),
        .m_rsp_valid_o  (lsu_rsp_valid_o), .m_rsp_ready_i  (lsu_rsp_ready_i),
        .m_rsp_rdata_o  (lsu_rsp_rdata_o), .m_rsp_resp_o   (lsu_rsp_resp_o),
        .s0_req_valid_o (lmem_req_valid),  .s0_req_ready_i (lmem_req_ready),
        .s0_req_write_o (lmem_req_write),  .s0_req_addr_o  (lmem_req_addr),
        .s0_req_wdata_o (lmem_req_wdata),  .s0_req_strb_o  (lmem_req_strb),
        .s0_rsp_valid_i (lmem_rsp_valid),  .s0_rsp_ready_o (lmem_rsp_ready),
        .s0_rsp_rdata_i (lmem_rsp_rdata),  .s0_rsp_resp_i  (lmem_rsp_resp),
        .s1_req_valid_o (dccm_req_valid),  .s1_req_ready_i (dccm_req_ready),
        .s1_req_write_o (dccm_req_write),  .s1_req_addr_o  (dccm_req_addr),
        .s1_req_wdata_o (dccm_req_wdata),  .s1_req_strb_o  (dccm_req_strb),
        .s1_rsp_valid_i (dccm_rsp_valid),  .s1_rsp_ready_o (dccm_rsp_ready),
        .s1_rsp_rdata_i (dccm_rsp_rdata),  .s1_rsp_resp_i  (dccm_rsp_resp)
    );

endmodule

//--- test/tb_rev_top.sv
// Testbench for rev_top with a stimulus table, reference memory model and response back-pressure
module tb_rev_top
    import soc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_WORDS = 256;
    localparam int LMEM_WORDS = 1024;
    localparam int DCCM_WORDS = 512;
    localparam int TIMEOUT    = 100;
    localparam int BP_COUNT   = 12;

    logic              core_clk;
    logic              rst_i;
    logic              ifu_req_valid_i;
    logic              ifu_req_ready_o;
    logic              ifu_req_write_i;
    logic [ADDR_W-1:0] ifu_req_addr_i;
    logic [DATA_W-1:0] ifu_req_wdata_i;
    logic [STRB_W-1:0] ifu_req_strb_i;
    logic              ifu_rsp_valid_o;
    logic              ifu_rsp_ready_i;
    logic [DATA_W-1:0] ifu_rsp_rdata_o;
    resp_e             ifu_rsp_resp_o;
    logic              lsu_req_valid_i;
    logic              lsu_req_ready_o;
    logic              lsu_req_write_i;
    logic [ADDR_W-1:0] lsu_req_addr_i;
    logic [DATA_W-1:0] lsu_req_wdata_i;
    logic [STRB_W-1:0] lsu_req_strb_i;
    logic              lsu_rsp_valid_o;
    logic              lsu_rsp_ready_i;
    logic [DATA_W-1:0] lsu_rsp_rdata_o;
    resp_e             lsu_rsp_resp_o;

    // Stimulus table with one entry per index
    string             t_name[$];
    bit                t_lsu[$];
    bit                t_write[$];
    logic [ADDR_W-1:0] t_addr[$];
    logic [DATA_W-1:0] t_wdata[$];
    logic [STRB_W-1:0] t_strb[$];
    logic [DATA_W-1:0] t_exp_data[$];
    logic [1:0]        t_exp_resp[$];

    // Reads issued under back-pressure
    logic [ADDR_W-1:0] bp_addr[$];
    logic [DATA_W-1:0] bp_exp[$];

    // Model words keyed by region and word index
    logic [DATA_W-1:0] model_mem[int];

    int pass_count;
    int fail_count;

    rev_top uut (
        .core_clk        (core_clk),
        .rst_i           (rst_i),
        .ifu_req_valid_i (ifu_req_valid_i),
        .ifu_req_ready_o (ifu_req_ready_o),
        .ifu_req_write_i (ifu_req_write_i),
        .ifu_req_addr_i  (ifu_req_addr_i),
        .ifu_req_wdata_i (ifu_req_wdata_i),
        .ifu_req_strb_i  (ifu_req_strb_i),
        .ifu_rsp_valid_o (ifu_rsp_valid_o),
        .ifu_rsp_ready_i (ifu_rsp_ready_i),
        .ifu_rsp_rdata_o (ifu_rsp_rdata_o),
        .ifu_rsp_resp_o  (ifu_rsp_resp_o),
        .lsu_req_valid_i (lsu_req_valid_i),
        .lsu_req_ready_o (lsu_req_ready_o),
        .lsu_req_write_i (lsu_req_write_i),
        .lsu_req_addr_i  (lsu_req_addr_i),
        .lsu_req_wdata_i (lsu_req_wdata_i),
        .lsu_req_strb_i  (lsu_req_strb_i),
        .lsu_rsp_valid_o (lsu_rsp_valid_o),
        .lsu_rsp_ready_i (lsu_rsp_ready_i),
        .lsu_rsp_rdata_o (lsu_rsp_rdata_o),
        .lsu_rsp_resp_o  (lsu_rsp_resp_o)
    );

    always #10 core_clk = ~core_clk;

    // Region 0 is imem, 1 lmem, 2 dccm and 3 unmapped
    function automatic int region_of(input bit lsu, input logic [ADDR_W-1:0] addr);
        if (!lsu)
            return 0;
        if (addr >= LMEM_BASE && addr < LMEM_BASE + LMEM_SIZE)
            return 1;
        if (addr >= DCCM_BASE && addr < DCCM_BASE + DCCM_SIZE)
            return 2;
        return 3;
    endfunction

    function automatic int word_key(input int region, input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] off;
        int                words;
        off   = addr;
        words = IMEM_WORDS;
        if (region == 1) begin
            off   = addr - LMEM_BASE;
            words = LMEM_WORDS;
        end else if (region == 2) begin
            off   = addr - DCCM_BASE;
            words = DCCM_WORDS;
        end
        // Byte offset ignored and index wrapped over the depth
        return region * 65536 + int'((off >> WORD_LSB) % words);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wdata,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Appends one entry and advances the model
    function automatic void add_entry(input string name, input bit lsu, input bit write,
                                      input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] wdata,
                                      input logic [STRB_W-1:0] strb);
        int                region;
        int                key;
        logic [DATA_W-1:0] old;
        logic [DATA_W-1:0] exp_data;
        logic [1:0]        exp_resp;
        region   = region_of(lsu, addr);
        key      = word_key(region, addr);
        exp_data = '0;
        exp_resp = RESP_OKAY;
        if (region == 3) begin
            exp_resp = RESP_DECERR;
        end else if (write) begin
            old = model_mem.exists(key) ? model_mem[key] : '0;
            model_mem[key] = merge_bytes(old, wdata, strb);
        end else begin
            exp_data = model_mem[key];
        end
        t_name.push_back(name);
        t_lsu.push_back(lsu);
        t_write.push_back(write);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_strb.push_back(strb);
        t_exp_data.push_back(exp_data);
        t_exp_resp.push_back(exp_resp);
    endfunction

    task automatic build_table();
        logic [ADDR_W-1:0] addr;
        // First fetch write to each word is a full one
        add_entry("ifu_wr_full", 0, 1, 32'h100, 64'h1122_3344_5566_7788, 8'hFF);
        add_entry("ifu_wr_low_half", 0, 1, 32'h100, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F);
        add_entry("ifu_wr_byte6", 0, 1, 32'h106, 64'h0099_0000_0000_0000, 8'h40);
        add_entry("ifu_rd_merged", 0, 0, 32'h100, '0, '0);
        add_entry("ifu_wr_word1", 0, 1, 32'h008, 64'h0F0F_1234_5678_F0F0, 8'hFF);
        add_entry("ifu_wr_wrap", 0, 1, 32'h808, 64'h0000_0000_0000_00A5, 8'h01);
        add_entry("ifu_rd_wrapped", 0, 0, 32'h008, '0, '0);
        add_entry("ifu_rd_alias", 0, 0, 32'h808, '0, '0);
        // Same offset in both regions
        add_entry("lsu_wr_lmem", 1, 1, 32'h40, 64'hDEAD_BEEF_0000_0001, 8'hFF);
        add_entry("lsu_wr_dccm", 1, 1, DCCM_BASE + 32'h40, 64'hCAFE_F00D_0000_0002, 8'hFF);
        add_entry("lsu_wr_dccm_upper", 1, 1, DCCM_BASE + 32'h40, 64'h1234_5678_9ABC_DEF0,
                  8'hF0);
        add_entry("lsu_rd_lmem", 1, 0, 32'h40, '0, '0);
        add_entry("lsu_rd_dccm", 1, 0, DCCM_BASE + 32'h40, '0, '0);
        // Just past each region where a wrong decode would alias offset 0x40
        add_entry("lsu_rd_unmapped", 1, 0, 32'h8000_0000, '0, '0);
        add_entry("lsu_wr_past_lmem", 1, 1, 32'h2040, 64'h5555_5555_5555_5555, 8'hFF);
        add_entry("lsu_wr_past_dccm", 1, 1, DCCM_BASE + 32'h1040, 64'h6666_6666_6666_6666,
                  8'hFF);
        add_entry("lsu_rd_lmem_kept", 1, 0, 32'h40, '0, '0);
        add_entry("lsu_rd_dccm_kept", 1, 0, DCCM_BASE + 32'h40, '0, '0);
        for (int k = 0; k < BP_COUNT / 2; k++) begin
            add_entry($sformatf("lsu_fill_lmem_%0d", k), 1, 1, 32'h200 + 32'(8 * k),
                      64'h1111_0000_0000_0000 + 64'(k) * 64'h0101, 8'hFF);
            add_entry($sformatf("lsu_fill_dccm_%0d", k), 1, 1,
                      DCCM_BASE + 32'h200 + 32'(8 * k),
                      64'h2222_0000_0000_0000 + 64'(k) * 64'h0303, 8'hFF);
        end
        // Alternating lmem and dccm reads of the filled words
        for (int k = 0; k < BP_COUNT; k++) begin
            addr = 32'h200 + 32'(8 * (k / 2));
            if (k % 2 == 1) begin
                addr = addr + DCCM_BASE;
            end
            bp_addr.push_back(addr);
            bp_exp.push_back(model_mem[word_key(region_of(1, addr), addr)]);
        end
    endtask

    function automatic logic req_ready_of(input bit lsu);
        return lsu ? lsu_req_ready_o : ifu_req_ready_o;
    endfunction

    function automatic logic rsp_valid_of(input bit lsu);
        return lsu ? lsu_rsp_valid_o : ifu_rsp_valid_o;
    endfunction

    task automatic drive_request(input bit lsu, input bit write, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        if (lsu) begin
            lsu_req_valid_i = 1'b1;
            lsu_req_write_i = write;
            lsu_req_addr_i  = addr;
            lsu_req_wdata_i = wdata;
            lsu_req_strb_i  = strb;
        end else begin
            ifu_req_valid_i = 1'b1;
            ifu_req_write_i = write;
            ifu_req_addr_i  = addr;
            ifu_req_wdata_i = wdata;
            ifu_req_strb_i  = strb;
        end
    endtask

    task automatic clear_requests();
        ifu_req_valid_i = 1'b0;
        ifu_req_write_i = 1'b0;
        ifu_req_addr_i  = '0;
        ifu_req_wdata_i = '0;
        ifu_req_strb_i  = '0;
        lsu_req_valid_i = 1'b0;
        lsu_req_write_i = 1'b0;
        lsu_req_addr_i  = '0;
        lsu_req_wdata_i = '0;
        lsu_req_strb_i  = '0;
    endtask

    task automatic report_result(input string name, input bit fine);
        if (fine) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    // One request and its response with outputs sampled 2 ns after the falling edge
    task automatic transfer(input bit lsu, input bit write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                            output logic [DATA_W-1:0] rdata, output logic [1:0] resp,
                            output bit ok);
        int waited;
        ok    = 1'b0;
        rdata = '0;
        resp  = '0;
        @(negedge core_clk);
        drive_request(lsu, write, addr, wdata, strb);
        #2;
        waited = 0;
        while (!req_ready_of(lsu) && waited < TIMEOUT) begin
            @(negedge core_clk);
            #2;
            waited++;
        end
        if (!req_ready_of(lsu)) begin
            $display("Request to address %h was never accepted", addr);
            @(negedge core_clk);
            clear_requests();
            return;
        end
        // Accepted on the next rising edge
        @(negedge core_clk);
        clear_requests();
        #2;
        waited = 0;
        while (!rsp_valid_of(lsu) && waited < TIMEOUT) begin
            @(negedge core_clk);
            #2;
            waited++;
        end
        if (!rsp_valid_of(lsu)) begin
            $display("No response arrived for address %h", addr);
            return;
        end
        rdata = lsu ? lsu_rsp_rdata_o : ifu_rsp_rdata_o;
        resp  = lsu ? lsu_rsp_resp_o : ifu_rsp_resp_o;
        ok    = 1'b1;
    endtask

    task automatic run_entry(input int i);
        logic [DATA_W-1:0] rdata;
        logic [1:0]        resp;
        bit                ok;
        bit                fine;
        transfer(t_lsu[i], t_write[i], t_addr[i], t_wdata[i], t_strb[i], rdata, resp, ok);
        fine = ok;
        if (ok && rdata !== t_exp_data[i]) begin
            $display("ERROR %s: data expected %h actual %h", t_name[i], t_exp_data[i], rdata);
            fine = 1'b0;
        end
        if (ok && resp !== t_exp_resp[i]) begin
            $display("ERROR %s: resp expected %0h actual %0h", t_name[i], t_exp_resp[i], resp);
            fine = 1'b0;
        end
        report_result(t_name[i], fine);
    endtask

    task automatic check_reset_state();
        bit fine;
        fine = 1'b1;
        #2;
        if (ifu_rsp_valid_o !== 1'b0) begin
            $display("ERROR reset_state: ifu_rsp_valid_o expected 0 actual %b", ifu_rsp_valid_o);
            fine = 1'b0;
        end
        if (lsu_rsp_valid_o !== 1'b0) begin
            $display("ERROR reset_state: lsu_rsp_valid_o expected 0 actual %b", lsu_rsp_valid_o);
            fine = 1'b0;
        end
        if (ifu_req_ready_o !== 1'b1) begin
            $display("ERROR reset_state: ifu_req_ready_o expected 1 actual %b", ifu_req_ready_o);
            fine = 1'b0;
        end
        if (lsu_req_ready_o !== 1'b1) begin
            $display("ERROR reset_state: lsu_req_ready_o expected 1 actual %b", lsu_req_ready_o);
            fine = 1'b0;
        end
        report_result("reset_state", fine);
    endtask

    task automatic check_backpressure();
        int                got;
        int                idle;
        int                waited;
        bit                fine;
        logic [DATA_W-1:0] data;
        fine = 1'b1;
        got  = 0;
        idle = 0;
        fork
            begin
                for (int k = 0; k < BP_COUNT; k++) begin
                    @(negedge core_clk);
                    drive_request(1'b1, 1'b0, bp_addr[k], '0, '0);
                    #2;
                    waited = 0;
                    while (!lsu_req_ready_o && waited < TIMEOUT) begin
                        @(negedge core_clk);
                        #2;
                        waited++;
                    end
                    if (!lsu_req_ready_o) begin
                        $display("Back-pressure read %0d was never accepted", k);
                        fine = 1'b0;
                        break;
                    end
                end
                @(negedge core_clk);
                clear_requests();
            end
            begin
                // Random gaps in response ready
                while (got < BP_COUNT && idle < TIMEOUT) begin
                    @(negedge core_clk);
                    lsu_rsp_ready_i = ($urandom % 3) != 0;
                    #2;
                    if (lsu_rsp_valid_o && lsu_rsp_ready_i) begin
                        data = lsu_rsp_rdata_o;
                        if (data !== bp_exp[got] || lsu_rsp_resp_o !== RESP_OKAY) begin
                            $display("ERROR %s: response %0d expected %h/%0h actual %h/%0h",
                                     "lsu_backpressure_order", got,
                                     bp_exp[got], RESP_OKAY, data, lsu_rsp_resp_o);
                            fine = 1'b0;
                        end
                        got++;
                        idle = 0;
                    end else begin
                        idle++;
                    end
                end
                if (got < BP_COUNT) begin
                    $display("Only %0d of %0d back-pressure responses arrived", got, BP_COUNT);
                    fine = 1'b0;
                end
            end
        join
        @(negedge core_clk);
        lsu_rsp_ready_i = 1'b1;
        // Nothing may remain once every read is answered
        repeat (4) begin
            #2;
            if (lsu_rsp_valid_o) begin
                $display("An extra load/store response appeared after the last read");
                fine = 1'b0;
            end
            @(negedge core_clk);
        end
        report_result("lsu_backpressure_order", fine);
    endtask

    initial begin
        void'($urandom(32'h859));
        core_clk        = 1'b0;
        rst_i           = 1'b1;
        // Response ready stays low until the reset state is checked
        ifu_rsp_ready_i = 1'b0;
        lsu_rsp_ready_i = 1'b0;
        clear_requests();
        pass_count = 0;
        fail_count = 0;
        build_table();

        repeat (16) @(negedge core_clk);
        rst_i = 1'b0;
        check_reset_state();
        @(negedge core_clk);
        ifu_rsp_ready_i = 1'b1;
        lsu_rsp_ready_i = 1'b1;

        for (int i = 0; i < t_name.size(); i++) begin
            run_entry(i);
        end
        check_backpressure();

        $display("Tests: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/soc_pkg.sv
mem/mem_slave.sv
bridge/resp_order_fifo.sv
bridge/lsu_bridge.sv
verilog/rev_top.sv
test/tb_rev_top.sv

//--- Makefile
TOP := tb_rev_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f vlog.f --top-module $(TOP)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
